// ==== src.f ====
+incdir+.
fp_pkg.sv
wb_pkg.sv
srt4_qsel.sv
srt4_div_core.sv
fp_div_unpack.sv
fp_div_round.sv
fpdiv_wb_regs.sv
fpdiv_top.sv
tb_fpdiv.sv

// ==== run.sh ====
#!/bin/sh
# build the fpdiv testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fpdiv -f src.f -o tb_fpdiv_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_fpdiv_sim)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

// ==== tb_fpdiv.sv ====
// tb_fpdiv
// directed testbench for the wishbone FP32 divider
// bit-exact reference divider, bus tasks, LFSR operands and a cycle limit
`timescale 1ns/1ps
`include "fpdiv_config.svh"

module tb_fpdiv;

  // roughly 30 cycles for each of ~220 divisions plus the register test
  localparam int max_cycles = 20000;

  logic             clk = 1'b0;
  logic             rst;
  logic             cyc;
  logic             stb;
  logic             we;
  wb_pkg::wb_addr_t adr;
  wb_pkg::wb_data_t dat_w;
  wb_pkg::wb_data_t dat_r;
  logic             ack;
  logic             irq;

  int          cycles = 0;
  int          n_pass;
  int          n_fail;
  int          t_checks;   // per test
  int          t_errors;
  logic [31:0] lfsr;

  fpdiv_top i_dut (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .irq(irq)
  );

  always #4 clk = ~clk;   // 8 ns period

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
      $display("Test failed");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1 with the new bit entering at 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);   // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // normal operand with exponent in 64 .. 191
  task automatic rand_normal(output logic [31:0] v);
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] m;
    rand_bits(1, s);
    rand_bits(7, e);
    rand_bits(23, m);
    v = {s[0], e[7:0] + 8'd64, m[22:0]};
  endtask

  // expected {flags, result} with flags as invalid, div_by_zero, overflow, underflow
  function automatic logic [35:0] ref_div(input logic [31:0] a, input logic [31:0] b);
    logic        s;
    logic        a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    logic [63:0] num;
    logic [63:0] den;
    logic [63:0] q;
    logic [63:0] r;
    logic [23:0] m;
    logic [24:0] mr;
    logic        half;
    logic        rest;
    int          e;
    s      = a[31] ^ b[31];
    a_zero = (a[30:23] == 8'h00);   // subnormals count as zero
    b_zero = (b[30:23] == 8'h00);
    a_inf  = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
    b_inf  = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
    a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) return {4'b1000, `FPDIV_QNAN};
    if (a_inf) return {4'b0000, s, 8'hff, 23'd0};
    if (b_zero) return {4'b0100, s, 8'hff, 23'd0};
    if (b_inf || a_zero) return {4'b0000, s, 31'd0};
    // long division to 26 quotient fraction bits
    num = {40'd0, 1'b1, a[22:0]} << 26;
    den = {40'd0, 1'b1, b[22:0]};
    q   = num / den;
    r   = num % den;
    e   = int'(a[30:23]) - int'(b[30:23]) + 127;
    if (q[26]) begin
      m    = q[26:3];
      half = q[2];
      rest = q[1] | q[0] | (r != 64'd0);
    end else begin
      m    = q[25:2];   // quotient below one
      half = q[1];
      rest = q[0] | (r != 64'd0);
      e    = e - 1;
    end
    mr = {1'b0, m} + {24'd0, half & (rest | m[0])};   // nearest even
    if (mr[24]) e = e + 1;
    if (e >= 255) return {4'b0010, s, 8'hff, 23'd0};
    if (e <= 0) return {4'b0001, s, 31'd0};
    return {4'b0000, s, e[7:0], mr[22:0]};
  endfunction

  task automatic wb_write(input wb_pkg::wb_addr_t a, input wb_pkg::wb_data_t d);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= a;
    dat_w <= d;
    @(negedge clk);
    while (!ack) @(negedge clk);   // ack sampled mid cycle
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_read(input wb_pkg::wb_addr_t a, output wb_pkg::wb_data_t d);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    @(negedge clk);
    while (!ack) @(negedge clk);
    d = dat_r;   // valid with ack
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  task automatic poll_done(output logic [31:0] st);
    st = '0;
    while (!st[wb_pkg::stat_done]) wb_read(`FPDIV_REG_CTRL, st);
  endtask

  task automatic divide(input logic [31:0] a, input logic [31:0] b, input logic [31:0] ctrl,
                        output logic [31:0] res, output logic [31:0] st);
    wb_write(`FPDIV_REG_A, a);
    wb_write(`FPDIV_REG_B, b);
    wb_write(`FPDIV_REG_CTRL, ctrl);
    poll_done(st);
    wb_read(`FPDIV_REG_RES, res);
    wb_read(`FPDIV_REG_CTRL, st);
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    t_checks = t_checks + 1;
    if (act !== exp) begin
      $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
      t_errors = t_errors + 1;
      n_fail   = n_fail + 1;
    end else begin
      n_pass = n_pass + 1;
    end
  endtask

  task automatic check_div(input string name, input logic [31:0] a, input logic [31:0] b);
    logic [35:0] exp;
    logic [31:0] res;
    logic [31:0] st;
    exp = ref_div(a, b);
    divide(a, b, 32'h1, res, st);
    check_word({name, " result"}, exp[31:0], res);
    check_word({name, " flags"}, {28'd0, exp[35:32]}, {28'd0, st[wb_pkg::stat_flags +: 4]});
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, t_checks, t_errors);
    t_checks = 0;
    t_errors = 0;
  endtask

  task automatic exact_quotients();
    check_div("6/3", 32'h40c00000, 32'h40400000);
    check_div("1/4", 32'h3f800000, 32'h40800000);
    check_div("-7.5/2.5", 32'hc0f00000, 32'h40200000);
    check_div("1/1", 32'h3f800000, 32'h3f800000);
    end_test("exact");
  endtask

  task automatic rounding_cases();
    check_div("1/3", 32'h3f800000, 32'h40400000);
    check_div("2/3", 32'h40000000, 32'h40400000);
    check_div("1/7", 32'h3f800000, 32'h40e00000);
    check_div("10/9", 32'h41200000, 32'h41100000);
    end_test("rounding");
  endtask

  task automatic special_cases();
    check_div("0/0", 32'h00000000, 32'h00000000);
    check_div("nan/1", 32'h7f800001, 32'h3f800000);
    check_div("inf/inf", 32'h7f800000, 32'hff800000);
    check_div("5/0", 32'h40a00000, 32'h00000000);
    check_div("-5/0", 32'hc0a00000, 32'h00000000);
    check_div("-inf/2", 32'hff800000, 32'h40000000);
    check_div("3/inf", 32'h40400000, 32'h7f800000);
    check_div("sub/1", 32'h00400000, 32'h3f800000);
    end_test("special");
  endtask

  task automatic range_limits();
    check_div("huge/tiny", 32'h7f7fffff, 32'h00800000);
    check_div("-huge/tiny", 32'hff000000, 32'h00800000);
    check_div("tiny/huge", 32'h00800000, 32'h7f7fffff);
    end_test("range");
  endtask

  task automatic random_pairs();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 200; i++) begin
      rand_normal(a);
      rand_normal(b);
      check_div($sformatf("rand %0d", i), a, b);
    end
    end_test("random");
  endtask

  task automatic register_behavior();
    logic [35:0] exp;
    logic [35:0] exp_second;
    logic [31:0] d;
    logic [31:0] st;
    exp        = ref_div(32'h40490fdb, 32'h402df854);
    exp_second = ref_div(32'h3f800000, 32'h402df854);
    wb_write(`FPDIV_REG_A, 32'h40490fdb);
    wb_write(`FPDIV_REG_B, 32'h402df854);
    wb_read(`FPDIV_REG_A, d);
    check_word("regs a readback", 32'h40490fdb, d);
    wb_read(`FPDIV_REG_B, d);
    check_word("regs b readback", 32'h402df854, d);
    // start with irq off and poke the busy core
    wb_write(`FPDIV_REG_CTRL, 32'h1);
    wb_write(`FPDIV_REG_A, 32'h3f800000);
    wb_write(`FPDIV_REG_B, 32'h3f800000);
    wb_write(`FPDIV_REG_CTRL, 32'h1);   // second start is dropped
    poll_done(st);
    wb_read(`FPDIV_REG_RES, d);
    check_word("regs busy result", exp[31:0], d);
    wb_read(`FPDIV_REG_A, d);
    check_word("regs busy a", 32'h40490fdb, d);
    @(negedge clk);
    check_word("regs irq off", 32'h0, {31'd0, irq});
    wb_write(`FPDIV_REG_CTRL, 32'h2);   // irq_en only while done is still set
    @(negedge clk);
    check_word("regs irq on", 32'h1, {31'd0, irq});
    wb_write(`FPDIV_REG_A, 32'h3f800000);   // fresh a gives a different second result
    // a new start clears done and so irq
    wb_write(`FPDIV_REG_CTRL, 32'h3);
    wb_read(`FPDIV_REG_CTRL, st);
    check_word("regs status after start", 32'h5, {29'd0, st[2:0]});   // busy, irq_en
    @(negedge clk);
    check_word("regs irq after start", 32'h0, {31'd0, irq});
    poll_done(st);
    @(negedge clk);
    check_word("regs irq after done", 32'h1, {31'd0, irq});
    wb_read(`FPDIV_REG_RES, d);
    check_word("regs second result", exp_second[31:0], d);
    wb_write(`FPDIV_REG_CTRL, 32'h0);
    @(negedge clk);
    check_word("regs irq disabled", 32'h0, {31'd0, irq});
    end_test("registers");
  endtask

  initial begin
    lfsr     = 32'hc689;
    n_pass   = 0;
    n_fail   = 0;
    t_checks = 0;
    t_errors = 0;
    rst   <= 1'b0;
    cyc   <= 1'b0;
    stb   <= 1'b0;
    we    <= 1'b0;
    adr   <= '0;
    dat_w <= '0;
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    exact_quotients();
    rounding_cases();
    special_cases();
    range_limits();
    random_pairs();
    register_behavior();
    $display("checks passed %0d, checks with errors %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== fpdiv_top.sv ====
// fpdiv_top
// memory mapped FP32 divider, wishbone register block in front of
// unpack, radix-4 SRT core and round / pack
`timescale 1ns/1ps

module fpdiv_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  wb_pkg::wb_addr_t adr,
  input  wb_pkg::wb_data_t dat_w,
  output wb_pkg::wb_data_t dat_r,
  output logic             ack,
  output logic             irq
);

  fp_pkg::fp32_t  op_a, op_b;
  fp_pkg::fp32_t  res, special_res;
  fp_pkg::mant_t  mant_a, mant_b;
  fp_pkg::exp_t   exp_diff;
  fp_pkg::quo_t   quo;
  wb_pkg::flags_t flags, special_flags;
  logic           start, done;
  logic           sign, is_special, rem_nonzero;

  fpdiv_wb_regs i_regs (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .irq(irq),
    .op_a(op_a), .op_b(op_b), .start(start), .done(done),
    .res(res), .flags(flags)
  );

  fp_div_unpack i_unpack (
    .a(op_a), .b(op_b), .mant_a(mant_a), .mant_b(mant_b),
    .exp_diff(exp_diff), .sign(sign), .is_special(is_special),
    .special_res(special_res), .special_flags(special_flags)
  );

  srt4_div_core i_core (
    .clk(clk), .rst(rst), .start(start), .mant_a(mant_a), .mant_b(mant_b),
    .quo(quo), .rem_nonzero(rem_nonzero), .done(done)
  );

  fp_div_round i_round (
    .quo(quo), .rem_nonzero(rem_nonzero), .exp_diff(exp_diff), .sign(sign),
    .is_special(is_special), .special_res(special_res),
    .special_flags(special_flags), .res(res), .flags(flags)
  );

endmodule

// ==== fpdiv_wb_regs.sv ====
// fpdiv_wb_regs
// wishbone classic slave with operand, control/status and result
// words, single cycle ack, start pulse and sticky done with irq
`timescale 1ns/1ps
`include "fpdiv_config.svh"

module fpdiv_wb_regs (
  input  logic             clk,
  input  logic             rst,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  wb_pkg::wb_addr_t adr,
  input  wb_pkg::wb_data_t dat_w,
  output wb_pkg::wb_data_t dat_r,
  output logic             ack,
  output logic             irq,
  output fp_pkg::fp32_t    op_a,
  output fp_pkg::fp32_t    op_b,
  output logic             start,
  input  logic             done,
  input  fp_pkg::fp32_t    res,
  input  wb_pkg::flags_t   flags
);

  logic             acc;        // access seen, not yet acked
  logic             wr;
  wb_pkg::reg_idx_t idx;
  logic             go;         // accepted start
  logic             busy;
  logic             done_bit;
  logic             irq_en;
  fp_pkg::fp32_t    res_q;
  wb_pkg::flags_t   flags_q;
  wb_pkg::wb_data_t status;

  assign acc = cyc & stb & ~ack;
  assign wr  = acc & we;
  assign idx = adr[3:2];
  assign go  = wr && (idx == wb_pkg::reg_idx_t'(`FPDIV_REG_CTRL >> 2))
               && dat_w[wb_pkg::ctrl_start] && !busy;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ack      <= 1'b0;
      start    <= 1'b0;
      busy     <= 1'b0;
      done_bit <= 1'b0;
      irq_en   <= 1'b0;
      op_a     <= '0;
      op_b     <= '0;
      res_q    <= '0;
      flags_q  <= '0;
    end else begin
      ack   <= acc;   // one cycle, drops even if stb stays up
      start <= go;    // high together with ack
      if (go) begin
        busy     <= 1'b1;
        done_bit <= 1'b0;
      end else if (done) begin
        busy     <= 1'b0;
        done_bit <= 1'b1;   // sticky until next start
        res_q    <= res;
        flags_q  <= flags;
      end
      if (wr && idx == wb_pkg::reg_idx_t'(`FPDIV_REG_CTRL >> 2))
        irq_en <= dat_w[wb_pkg::ctrl_irq_en];
      if (wr && !busy && idx == wb_pkg::reg_idx_t'(`FPDIV_REG_A >> 2)) op_a <= dat_w;
      if (wr && !busy && idx == wb_pkg::reg_idx_t'(`FPDIV_REG_B >> 2)) op_b <= dat_w;
    end
  end

  always_comb begin
    status                                       = '0;
    status[wb_pkg::stat_busy]                    = busy;
    status[wb_pkg::stat_done]                    = done_bit;
    status[wb_pkg::stat_irq_en]                  = irq_en;
    status[wb_pkg::stat_flags +: $bits(flags_q)] = flags_q;
  end

  // read mux, master holds adr while ack is high
  always_comb begin
    case (idx)
      wb_pkg::reg_idx_t'(`FPDIV_REG_A >> 2):    dat_r = op_a;
      wb_pkg::reg_idx_t'(`FPDIV_REG_B >> 2):    dat_r = op_b;
      wb_pkg::reg_idx_t'(`FPDIV_REG_CTRL >> 2): dat_r = status;
      default:                                  dat_r = res_q;   // result word
    endcase
  end

  assign irq = done_bit & irq_en;

endmodule

// ==== fp_div_round.sv ====
// fp_div_round
// normalizes the core quotient from [1/2, 2) into [1, 2),
// rounds to nearest even on guard / round / sticky,
// checks exponent range and packs, or passes the special result
`timescale 1ns/1ps

module fp_div_round (
  input  fp_pkg::quo_t   quo,
  input  logic           rem_nonzero,
  input  fp_pkg::exp_t   exp_diff,
  input  logic           sign,
  input  logic           is_special,
  input  fp_pkg::fp32_t  special_res,
  input  wb_pkg::flags_t special_flags,
  output fp_pkg::fp32_t  res,
  output wb_pkg::flags_t flags
);

  fp_pkg::mant_t  mant;       // 24 bits before rounding
  logic           guard;
  logic           rnd;
  logic           sticky;
  logic           inc;
  logic [24:0]    mant_sum;   // bit 24 is the rounding carry
  fp_pkg::exp_t   exp_n;
  fp_pkg::exp_t   exp_r;
  logic           ovf;
  logic           unf;
  fp_pkg::fp32_t  norm_res;
  wb_pkg::flags_t norm_flags;

  // binary point sits at bit 26 of quo
  always_comb begin
    if (quo[26]) begin
      mant   = quo[26:3];
      guard  = quo[2];
      rnd    = quo[1];
      sticky = quo[0] | rem_nonzero;
      exp_n  = exp_diff;
    end else begin
      mant   = quo[25:2];                 // one bit left shift
      guard  = quo[1];
      rnd    = quo[0];
      sticky = rem_nonzero;
      exp_n  = exp_diff - 10'sd1;
    end
  end

  assign inc      = guard & (rnd | sticky | mant[0]);   // ties to even
  assign mant_sum = {1'b0, mant} + {24'd0, inc};
  assign exp_r    = exp_n + (mant_sum[24] ? 10'sd1 : 10'sd0);  // carry into next binade

  assign ovf = (exp_r >= 10'sd255);
  assign unf = (exp_r <= 10'sd0);

  always_comb begin
    norm_flags                         = '0;
    norm_flags[wb_pkg::flag_overflow]  = ovf;
    norm_flags[wb_pkg::flag_underflow] = unf;
    if (ovf) begin
      norm_res = {sign, 8'hff, 23'd0};
    end else if (unf) begin
      norm_res = {sign, 31'd0};           // flush to zero
    end else begin
      norm_res = {sign, exp_r[7:0], mant_sum[22:0]};   // carry leaves frac zero
    end
  end

  assign res   = is_special ? special_res : norm_res;
  assign flags = is_special ? special_flags : norm_flags;

endmodule

// ==== fp_div_unpack.sv ====
// fp_div_unpack
// splits both operands, flushes subnormals, adds hidden bits,
// forms sign and biased exponent difference, and decodes the
// NaN / infinity / zero cases into a ready special result
`timescale 1ns/1ps
`include "fpdiv_config.svh"

module fp_div_unpack (
  input  fp_pkg::fp32_t  a,
  input  fp_pkg::fp32_t  b,
  output fp_pkg::mant_t  mant_a,
  output fp_pkg::mant_t  mant_b,
  output fp_pkg::exp_t   exp_diff,
  output logic           sign,
  output logic           is_special,
  output fp_pkg::fp32_t  special_res,
  output wb_pkg::flags_t special_flags
);

  logic [7:0] ea;
  logic [7:0] eb;
  logic       a_zero, b_zero;   // true zero or flushed subnormal
  logic       a_inf, b_inf;
  logic       a_nan, b_nan;

  assign ea = a[30:23];
  assign eb = b[30:23];

  assign a_zero = (ea == 8'h00);
  assign b_zero = (eb == 8'h00);
  assign a_inf  = (ea == 8'hff) && (a[22:0] == '0);
  assign b_inf  = (eb == 8'hff) && (b[22:0] == '0);
  assign a_nan  = (ea == 8'hff) && (a[22:0] != '0);
  assign b_nan  = (eb == 8'hff) && (b[22:0] != '0);

  assign mant_a = a_zero ? '0 : {1'b1, a[22:0]};
  assign mant_b = b_zero ? '0 : {1'b1, b[22:0]};
  assign sign   = a[31] ^ b[31];

  // ea - eb + bias, range -127 .. 381
  assign exp_diff = fp_pkg::exp_t'({2'b00, ea}) - fp_pkg::exp_t'({2'b00, eb}) + 10'sd127;

  always_comb begin
    special_flags = '0;
    special_res   = '0;
    is_special    = 1'b1;
    if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
      special_res                       = `FPDIV_QNAN;
      special_flags[wb_pkg::flag_invalid] = 1'b1;
    end else if (a_inf) begin
      special_res = {sign, 8'hff, 23'd0};    // inf / x, also inf / 0
    end else if (b_zero) begin
      special_res                          = {sign, 8'hff, 23'd0};
      special_flags[wb_pkg::flag_div_zero] = 1'b1;
    end else if (b_inf || a_zero) begin
      special_res = {sign, 31'd0};           // signed zero
    end else begin
      is_special = 1'b0;                     // both normal
    end
  end

endmodule

// ==== srt4_div_core.sv ====
// srt4_div_core
// iterative radix-4 SRT mantissa divider, one digit per cycle
// non-redundant remainder with 26 fraction bits, starts at a/4 so
// the quotient a/b lands in [2^25, 2^27) of the 28-bit result
// quotient built by on-the-fly conversion in the q / qm pair
`timescale 1ns/1ps
`include "fpdiv_config.svh"

module srt4_div_core (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  fp_pkg::mant_t mant_a,
  input  fp_pkg::mant_t mant_b,
  output fp_pkg::quo_t  quo,
  output logic          rem_nonzero,
  output logic          done
);

  fp_pkg::div_state_t state;
  logic [3:0]         cnt;        // iterations done
  logic signed [29:0] rem;        // partial remainder w
  logic [25:0]        dvs;        // divisor in remainder units
  fp_pkg::quo_t       q;
  fp_pkg::quo_t       qm;         // always q minus one digit ulp
  logic signed [29:0] rem_sh;     // 4w
  logic [29:0]        mult;       // |digit| * d
  logic signed [29:0] rem_next;
  logic [29:0]        rem_fix;    // remainder after negative correction
  fp_pkg::qdigit_t    digit;
  fp_pkg::quo_t       q_next;
  fp_pkg::quo_t       qm_next;

  assign rem_sh = {rem[27:0], 2'b00};

  srt4_qsel i_qsel (
    .rem_top (rem_sh[28:22]),
    .div_top (dvs[24:22]),
    .digit   (digit)
  );

  // divisor multiple
  always_comb begin
    case (digit)
      3'sd2, -3'sd2: mult = {3'b000, dvs, 1'b0};
      3'sd1, -3'sd1: mult = {4'b0000, dvs};
      default:       mult = '0;
    endcase
  end

  // negative digit adds the multiple back
  assign rem_next = digit[2] ? rem_sh + mult : rem_sh - mult;

  // on-the-fly conversion, no carry chain
  always_comb begin
    case (digit)
      3'sd2: begin
        q_next  = {q[25:0], 2'd2};
        qm_next = {q[25:0], 2'd1};
      end
      3'sd1: begin
        q_next  = {q[25:0], 2'd1};
        qm_next = {q[25:0], 2'd0};
      end
      -3'sd1: begin
        q_next  = {qm[25:0], 2'd3};
        qm_next = {qm[25:0], 2'd2};
      end
      -3'sd2: begin
        q_next  = {qm[25:0], 2'd2};
        qm_next = {qm[25:0], 2'd1};
      end
      default: begin   // zero digit
        q_next  = {q[25:0], 2'd0};
        qm_next = {qm[25:0], 2'd3};
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= fp_pkg::st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        fp_pkg::st_idle: begin
          if (start) begin
            state <= fp_pkg::st_iterate;
            cnt   <= '0;
          end
        end
        fp_pkg::st_iterate: begin
          cnt <= cnt + 4'd1;
          if (cnt == 4'(`FPDIV_ITER - 1)) state <= fp_pkg::st_finish;
        end
        default: state <= fp_pkg::st_idle;   // finish lasts one cycle
      endcase
    end
  end

  // datapath, loaded on start
  always_ff @(posedge clk) begin
    if (state == fp_pkg::st_idle && start) begin
      rem <= {6'b000000, mant_a};   // w0 = a/4
      dvs <= {mant_b, 2'b00};
      q   <= '0;
      qm  <= '0;
    end else if (state == fp_pkg::st_iterate) begin
      rem <= rem_next;
      q   <= q_next;
      qm  <= qm_next;
    end
  end

  // final correction, negative remainder means q is one too big
  assign rem_fix     = rem + {4'b0000, dvs};
  assign quo         = rem[29] ? qm : q;
  assign rem_nonzero = rem[29] ? (rem_fix != '0) : (rem != '0);
  assign done        = (state == fp_pkg::st_finish);

endmodule

// ==== srt4_qsel.sv ====
// srt4_qsel
// radix-4 quotient digit selection over the digit set -2 .. +2
// compares the truncated shifted remainder (3 int + 4 frac bits)
// with four thresholds picked by the divisor interval
`timescale 1ns/1ps

module srt4_qsel (
  input  logic [6:0]      rem_top,   // 4w truncated to 1/16
  input  logic [2:0]      div_top,   // divisor bits after the leading one
  output fp_pkg::qdigit_t digit
);

  logic signed [6:0] y;
  logic signed [6:0] m_two;    // select +2 at or above
  logic signed [6:0] m_one;    // select +1 at or above
  logic signed [6:0] m_zero;   // select 0 at or above
  logic signed [6:0] m_neg;    // select -1 at or above, else -2

  assign y = rem_top;

  // thresholds in 1/16 units for d in [(8+i)/16, (9+i)/16)
  always_comb begin
    case (div_top)
      3'd0:    {m_two, m_one, m_zero, m_neg} = {7'sd13, 7'sd4, -7'sd4, -7'sd13};
      3'd1:    {m_two, m_one, m_zero, m_neg} = {7'sd14, 7'sd4, -7'sd4, -7'sd14};
      3'd2:    {m_two, m_one, m_zero, m_neg} = {7'sd16, 7'sd5, -7'sd5, -7'sd16};
      3'd3:    {m_two, m_one, m_zero, m_neg} = {7'sd17, 7'sd6, -7'sd6, -7'sd17};
      3'd4:    {m_two, m_one, m_zero, m_neg} = {7'sd18, 7'sd6, -7'sd6, -7'sd19};
      3'd5:    {m_two, m_one, m_zero, m_neg} = {7'sd20, 7'sd7, -7'sd7, -7'sd20};
      3'd6:    {m_two, m_one, m_zero, m_neg} = {7'sd21, 7'sd7, -7'sd7, -7'sd22};
      default: {m_two, m_one, m_zero, m_neg} = {7'sd23, 7'sd8, -7'sd8, -7'sd23};
    endcase
  end

  always_comb begin
    if (y >= m_two) begin
      digit = 3'sd2;
    end else if (y >= m_one) begin
      digit = 3'sd1;
    end else if (y >= m_zero) begin
      digit = 3'sd0;
    end else if (y >= m_neg) begin
      digit = -3'sd1;
    end else begin
      digit = -3'sd2;   // far negative remainder
    end
  end

endmodule

// ==== wb_pkg.sv ====
// wb_pkg
// wishbone word and address types, register index and bit positions
package wb_pkg;

  typedef logic [31:0] wb_data_t;
  typedef logic [3:0]  wb_addr_t;   // byte address, [3:2] picks the word
  typedef logic [1:0]  reg_idx_t;   // word index
  typedef logic [3:0]  flags_t;     // invalid, div_by_zero, overflow, underflow

  localparam int ctrl_start  = 0;   // control write bits
  localparam int ctrl_irq_en = 1;
  localparam int stat_busy   = 0;   // status read bits
  localparam int stat_done   = 1;
  localparam int stat_irq_en = 2;
  localparam int stat_flags  = 4;   // lsb of the 4-bit flag field
  localparam int flag_invalid   = 3;
  localparam int flag_div_zero  = 2;
  localparam int flag_overflow  = 1;
  localparam int flag_underflow = 0;

endpackage

// ==== fp_pkg.sv ====
// fp_pkg
// field types of the FP32 datapath and the divider core state
package fp_pkg;

  // packed single precision word
  typedef logic [31:0] fp32_t;

  // mantissa with hidden bit at 23
  typedef logic [23:0] mant_t;

  // biased exponent, signed and wide enough for over/underflow range
  typedef logic signed [9:0] exp_t;

  // converted quotient, 14 radix-4 digits, binary point at 26
  typedef logic [27:0] quo_t;

  // signed quotient digit, -2 .. +2
  typedef logic signed [2:0] qdigit_t;

  typedef enum logic [1:0] {st_idle, st_iterate, st_finish} div_state_t;

endpackage

// ==== fpdiv_config.svh ====
// fpdiv configuration
// iteration count, register byte offsets and the canonical quiet NaN
// shared by the core, the register block and the testbench
`ifndef FPDIV_CONFIG_SVH
`define FPDIV_CONFIG_SVH

// radix-4 digits per division, 28 quotient bits
`define FPDIV_ITER 14

// wishbone byte offsets
`define FPDIV_REG_A    4'h0
`define FPDIV_REG_B    4'h4
`define FPDIV_REG_CTRL 4'h8
`define FPDIV_REG_RES  4'hC

// result of any invalid operation
`define FPDIV_QNAN 32'h7fc00000

`endif
